// File: all.f
hw/ecc_arith_pkg.sv
hw/ecc_flow_pkg.sv
hw/ksa_adder.sv
hw/cmd_credit_buffer.sv
hw/signed_add_sub.sv
hw/signed_arith_top.sv
verif/tb_signed_arith.sv

// File: Bender.yml
package:
  name: signed_arith

sources:
  # packages first
  - hw/ecc_arith_pkg.sv
  - hw/ecc_flow_pkg.sv
  # design
  - hw/ksa_adder.sv
  - hw/cmd_credit_buffer.sv
  - hw/signed_add_sub.sv
  - hw/signed_arith_top.sv
  # testbench
  - target: test
    files:
      - verif/tb_signed_arith.sv

// File: verif/tb_signed_arith.sv
`timescale 1ns/100ps

module tb_signed_arith;

  import ecc_arith_pkg::*;
  import ecc_flow_pkg::*;

  localparam logic [15:0] SEED = 16'd62039;
  localparam int TIMEOUT = 200;
  localparam int MIX_COUNT = 200;
  // stimulus flavours for random commands
  localparam int K_ADD = 0;
  localparam int K_GE = 1;
  localparam int K_LT = 2;
  localparam int K_EQ = 3;
  localparam int K_MIX = 4;

  logic              clk;
  logic              reset_n;
  logic              cmd_valid_i;
  arith_op_e         cmd_op_i;
  logic [WORD_W-1:0] cmd_a_i;
  logic              cmd_a_sign_i;
  logic [WORD_W-1:0] cmd_b_i;
  logic              cmd_b_sign_i;
  logic              credit_o;
  logic              resp_valid_o;
  logic [WORD_W-1:0] resp_mag_o;
  logic              resp_sign_o;
  logic              resp_carry_o;

  // expected results, oldest first
  logic [WORD_W-1:0] exp_mag_q [$];
  logic              exp_sign_q [$];
  logic              exp_carry_q [$];
  string             exp_name_q [$];

  logic [15:0] lfsr_q;
  int credits;
  int stall_cycles;
  int test_checks;
  int test_errors;
  int tests_passed;
  int tests_failed;

  signed_arith_top dut_i (
    .clk          (clk),
    .reset_n      (reset_n),
    .cmd_valid_i  (cmd_valid_i),
    .cmd_op_i     (cmd_op_i),
    .cmd_a_i      (cmd_a_i),
    .cmd_a_sign_i (cmd_a_sign_i),
    .cmd_b_i      (cmd_b_i),
    .cmd_b_sign_i (cmd_b_sign_i),
    .credit_o     (credit_o),
    .resp_valid_o (resp_valid_o),
    .resp_mag_o   (resp_mag_o),
    .resp_sign_o  (resp_sign_o),
    .resp_carry_o (resp_carry_o)
  );

  // 8 ns period
  always #4 clk = ~clk;

  ////////////////////
  // stimulus helpers
  ////////////////////

  // galois lfsr, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return (s >> 1) ^ (s[0] ? 16'hB400 : 16'h0000);
  endfunction

  // one lfsr step per bit
  task automatic take_bit(output logic bit_o);
    bit_o  = lfsr_q[0];
    lfsr_q = lfsr_next(lfsr_q);
  endtask

  task automatic take_word(output logic [WORD_W-1:0] word_o);
    logic b;
    word_o = '0;
    for (int i = 0; i < WORD_W; i++) begin
      take_bit(b);
      word_o = {word_o[WORD_W-2:0], b};
    end
  endtask

  // expected value straight from the signed-magnitude rule
  function automatic void ref_result(input arith_op_e op, input logic [WORD_W-1:0] a,
                                     input logic a_sign, input logic [WORD_W-1:0] b,
                                     input logic b_sign, output logic [WORD_W-1:0] mag,
                                     output logic sign, output logic carry);
    logic            eff_sub;
    logic [WORD_W:0] full;
    eff_sub = ((op == OP_SUB) && (a_sign == b_sign)) || ((op == OP_ADD) && (a_sign != b_sign));
    if (!eff_sub) begin
      full  = {1'b0, a} + {1'b0, b};
      mag   = full[WORD_W-1:0];
      carry = full[WORD_W];
      sign  = a_sign;
    end else begin
      carry = 1'b0;
      if (a >= b) begin
        mag  = a - b;
        sign = a_sign;
      end else begin
        mag  = b - a;
        sign = ~a_sign;
      end
    end
    // no negative zero
    if (mag == '0) begin
      sign = 1'b0;
    end
  endfunction

  task automatic fail_timeout(input string what);
    $display("timeout after %0d cycles while waiting for %s", TIMEOUT, what);
    $display("Test failed");
    $finish;
  endtask

  // returns aligned 1 ns after a rising edge
  task automatic wait_credit();
    int cnt;
    cnt = 0;
    while (credits == 0) begin
      if (cnt >= TIMEOUT) begin
        fail_timeout("a returned credit");
      end
      @(posedge clk);
      #1;
      cnt++;
      stall_cycles++;
    end
  endtask

  task automatic wait_drain();
    int cnt;
    cnt = 0;
    while (exp_mag_q.size() != 0) begin
      if (cnt >= TIMEOUT) begin
        fail_timeout("outstanding results");
      end
      @(posedge clk);
      #1;
      cnt++;
    end
  endtask

  // one command per call, spends one credit
  task automatic send_cmd(input arith_op_e op, input logic [WORD_W-1:0] a, input logic a_sign,
                          input logic [WORD_W-1:0] b, input logic b_sign, input string name);
    logic [WORD_W-1:0] mag;
    logic              sign;
    logic              carry;
    wait_credit();
    ref_result(op, a, a_sign, b, b_sign, mag, sign, carry);
    exp_mag_q.push_back(mag);
    exp_sign_q.push_back(sign);
    exp_carry_q.push_back(carry);
    exp_name_q.push_back(name);
    cmd_valid_i  = 1'b1;
    cmd_op_i     = op;
    cmd_a_i      = a;
    cmd_a_sign_i = a_sign;
    cmd_b_i      = b;
    cmd_b_sign_i = b_sign;
    credits--;
    @(posedge clk);
    #1;
    cmd_valid_i = 1'b0;
  endtask

  task automatic send_random(input string name, input int kind);
    logic [WORD_W-1:0] a;
    logic [WORD_W-1:0] b;
    logic [WORD_W-1:0] t;
    logic [2:0]        pick;
    logic              as;
    logic              bs;
    logic              sel;
    arith_op_e         op;
    take_word(a);
    take_word(b);
    take_bit(as);
    take_bit(bs);
    take_bit(sel);
    op = sel ? OP_SUB : OP_ADD;
    case (kind)
      // subtract exactly when the signs differ
      K_ADD: op = (as != bs) ? OP_SUB : OP_ADD;
      K_GE, K_LT, K_EQ: begin
        // equal signs for subtract, opposite for add
        bs = sel ? as : ~as;
        if (kind == K_EQ) begin
          b = a;
        end else if ((kind == K_GE) == (a < b)) begin
          t = a;
          a = b;
          b = t;
        end
      end
      default: begin
        for (int i = 0; i < 3; i++) begin
          take_bit(pick[i]);
        end
        // sprinkle in equal magnitudes
        if (pick == 3'd0) begin
          b = a;
        end
      end
    endcase
    send_cmd(op, a, as, b, bs, name);
  endtask

  ////////////////////
  // checking
  ////////////////////

  task automatic check_mag(input string name, input logic [WORD_W-1:0] exp_v,
                           input logic [WORD_W-1:0] act_v);
    test_checks++;
    if (act_v !== exp_v) begin
      $display("MISMATCH %s magnitude: expected %h actual %h", name, exp_v, act_v);
      test_errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp_v, input logic act_v);
    test_checks++;
    if (act_v !== exp_v) begin
      $display("MISMATCH %s: expected %b actual %b", name, exp_v, act_v);
      test_errors++;
    end
  endtask

  // outputs settle well before the falling edge
  always @(negedge clk) begin
    if (reset_n && credit_o) begin
      credits++;
    end
    if (credits < 0 || credits > CMD_DEPTH) begin
      $display("credit count out of range, %0d outstanding", CMD_DEPTH - credits);
      test_errors++;
    end
    if (reset_n && resp_valid_o) begin
      if (exp_mag_q.size() == 0) begin
        $display("result arrived with no command outstanding");
        test_errors++;
      end else begin
        check_mag(exp_name_q[0], exp_mag_q.pop_front(), resp_mag_o);
        check_flag({exp_name_q[0], " sign"}, exp_sign_q.pop_front(), resp_sign_o);
        check_flag({exp_name_q[0], " carry"}, exp_carry_q.pop_front(), resp_carry_o);
        void'(exp_name_q.pop_front());
      end
    end
  end

  // drain, then one report line per test
  task automatic end_test(input string name);
    wait_drain();
    if (test_errors == 0) begin
      $display("test %s: %0d checks, ok", name, test_checks);
      tests_passed++;
    end else begin
      $display("test %s: %0d checks, %0d errors", name, test_checks, test_errors);
      tests_failed++;
    end
    test_checks = 0;
    test_errors = 0;
  endtask

  ////////////////////
  // test sequence
  ////////////////////

  initial begin
    clk          = 1'b0;
    reset_n      = 1'b0;
    cmd_valid_i  = 1'b0;
    cmd_op_i     = OP_ADD;
    cmd_a_i      = '0;
    cmd_a_sign_i = 1'b0;
    cmd_b_i      = '0;
    cmd_b_sign_i = 1'b0;
    lfsr_q       = SEED;
    credits      = CMD_DEPTH;
    stall_cycles = 0;
    test_checks  = 0;
    test_errors  = 0;
    tests_passed = 0;
    tests_failed = 0;
    repeat (3) @(posedge clk);
    #1;
    reset_n = 1'b1;
    @(posedge clk);
    #1;

    // positive plus positive, negative minus positive, wrap to zero
    send_cmd(OP_ADD, 256'd1000, 1'b0, 256'd234, 1'b0, "add_pos_pos");
    send_cmd(OP_SUB, 256'd77, 1'b1, 256'd5, 1'b0, "sub_neg_pos");
    send_cmd(OP_ADD, '1, 1'b0, 256'd1, 1'b0, "add_all_ones");
    for (int i = 0; i < 6; i++) begin
      send_random("add_random", K_ADD);
    end
    end_test("effective_add");

    send_cmd(OP_SUB, 256'd900, 1'b1, 256'd300, 1'b1, "sub_ge_fixed");
    for (int i = 0; i < 6; i++) begin
      send_random("sub_ge_random", K_GE);
    end
    end_test("sub_a_ge_b");

    send_cmd(OP_ADD, 256'd3, 1'b0, 256'd10, 1'b1, "add_lt_fixed");
    for (int i = 0; i < 6; i++) begin
      send_random("sub_lt_random", K_LT);
    end
    end_test("sub_a_lt_b");

    send_cmd(OP_SUB, '0, 1'b1, '0, 1'b1, "sub_zero_zero");
    for (int i = 0; i < 4; i++) begin
      send_random("sub_eq_random", K_EQ);
    end
    end_test("sub_equal");

    // full burst of two-pass commands, the rest stall on credits
    stall_cycles = 0;
    for (int i = 0; i < 2 * CMD_DEPTH; i++) begin
      send_random("credit_burst", K_LT);
    end
    if (stall_cycles == 0) begin
      $display("sender never ran out of credits during the burst");
      test_errors++;
    end
    wait_drain();
    if (credits != CMD_DEPTH) begin
      $display("only %0d of %0d credits came back", credits, CMD_DEPTH);
      test_errors++;
    end
    end_test("credit_flow");

    for (int i = 0; i < MIX_COUNT; i++) begin
      send_random("mix", K_MIX);
    end
    end_test("random_mix");

    $display("summary: %0d tests passed, %0d tests failed", tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: hw/signed_arith_top.sv
`timescale 1ns/100ps

module signed_arith_top (
  input  logic                             clk,
  input  logic                             reset_n,
  // commands, one credit each
  input  logic                             cmd_valid_i,
  input  ecc_arith_pkg::arith_op_e         cmd_op_i,
  input  logic [ecc_arith_pkg::WORD_W-1:0] cmd_a_i,
  input  logic                             cmd_a_sign_i,
  input  logic [ecc_arith_pkg::WORD_W-1:0] cmd_b_i,
  input  logic                             cmd_b_sign_i,
  output logic                             credit_o,
  // results, always accepted
  output logic                             resp_valid_o,
  output logic [ecc_arith_pkg::WORD_W-1:0] resp_mag_o,
  output logic                             resp_sign_o,
  output logic                             resp_carry_o
);

  import ecc_arith_pkg::*;

  // buffer head toward the wrapper
  logic              buf_valid;
  logic              buf_pop;
  arith_op_e         buf_op;
  logic [WORD_W-1:0] buf_a;
  logic [WORD_W-1:0] buf_b;
  logic              buf_a_sign;
  logic              buf_b_sign;

  // wrapper <-> adder
  logic              add_valid;
  logic [WORD_W-1:0] add_a;
  logic [WORD_W-1:0] add_b;
  logic              add_cin;
  logic              add_sum_valid;
  logic [WORD_W-1:0] add_sum;
  logic              add_cout;

  cmd_credit_buffer cmd_buf_i (
    .clk           (clk),
    .reset_n       (reset_n),
    .cmd_valid_i   (cmd_valid_i),
    .cmd_op_i      (cmd_op_i),
    .cmd_a_i       (cmd_a_i),
    .cmd_b_i       (cmd_b_i),
    .cmd_a_sign_i  (cmd_a_sign_i),
    .cmd_b_sign_i  (cmd_b_sign_i),
    .pop_i         (buf_pop),
    .head_valid_o  (buf_valid),
    .head_op_o     (buf_op),
    .head_a_o      (buf_a),
    .head_b_o      (buf_b),
    .head_a_sign_o (buf_a_sign),
    .head_b_sign_o (buf_b_sign),
    .credit_o      (credit_o)
  );

  signed_add_sub ctrl_i (
    .clk           (clk),
    .reset_n       (reset_n),
    .head_valid_i  (buf_valid),
    .head_op_i     (buf_op),
    .head_a_i      (buf_a),
    .head_b_i      (buf_b),
    .head_a_sign_i (buf_a_sign),
    .head_b_sign_i (buf_b_sign),
    .pop_o         (buf_pop),
    .add_valid_o   (add_valid),
    .add_a_o       (add_a),
    .add_b_o       (add_b),
    .add_cin_o     (add_cin),
    .sum_valid_i   (add_sum_valid),
    .sum_i         (add_sum),
    .cout_i        (add_cout),
    .resp_valid_o  (resp_valid_o),
    .resp_mag_o    (resp_mag_o),
    .resp_sign_o   (resp_sign_o),
    .resp_carry_o  (resp_carry_o)
  );

  ksa_adder adder_i (
    .clk     (clk),
    .reset_n (reset_n),
    .valid_i (add_valid),
    .a_i     (add_a),
    .b_i     (add_b),
    .cin_i   (add_cin),
    .valid_o (add_sum_valid),
    .sum_o   (add_sum),
    .cout_o  (add_cout)
  );

endmodule

// File: hw/signed_add_sub.sv
`timescale 1ns/100ps

module signed_add_sub (
  input  logic                             clk,
  input  logic                             reset_n,
  // command buffer head
  input  logic                             head_valid_i,
  input  ecc_arith_pkg::arith_op_e         head_op_i,
  input  logic [ecc_arith_pkg::WORD_W-1:0] head_a_i,
  input  logic [ecc_arith_pkg::WORD_W-1:0] head_b_i,
  input  logic                             head_a_sign_i,
  input  logic                             head_b_sign_i,
  output logic                             pop_o,
  // adder issue
  output logic                             add_valid_o,
  output logic [ecc_arith_pkg::WORD_W-1:0] add_a_o,
  output logic [ecc_arith_pkg::WORD_W-1:0] add_b_o,
  output logic                             add_cin_o,
  // adder return
  input  logic                             sum_valid_i,
  input  logic [ecc_arith_pkg::WORD_W-1:0] sum_i,
  input  logic                             cout_i,
  // result
  output logic                             resp_valid_o,
  output logic [ecc_arith_pkg::WORD_W-1:0] resp_mag_o,
  output logic                             resp_sign_o,
  output logic                             resp_carry_o
);

  import ecc_arith_pkg::*;
  import ecc_flow_pkg::*;

  unit_state_e state_q;

  // captured operands, kept for a possible swapped pass
  logic [WORD_W-1:0] a_q;
  logic [WORD_W-1:0] b_q;
  logic              sign_a_q;
  logic              eff_sub_q;

  logic head_eff_sub;
  logic borrow;
  logic issue_p2;
  logic finish;
  logic res_sign;

  ////////////////////
  // decode
  ////////////////////

  // subtract when opcode and sign difference disagree
  assign head_eff_sub = (head_op_i == OP_SUB) ^ (head_a_sign_i ^ head_b_sign_i);

  // take a command only when nothing is in flight
  assign pop_o = (state_q == ST_IDLE) && head_valid_i;

  // no carry out on A + ~B + 1 means B was larger
  assign borrow   = eff_sub_q & ~cout_i;
  assign issue_p2 = (state_q == ST_PASS1) && sum_valid_i && borrow;
  assign finish   = sum_valid_i &&
                    (((state_q == ST_PASS1) && !borrow) || (state_q == ST_PASS2));

  // second pass flips the sign of A, zero is always positive
  assign res_sign = ((state_q == ST_PASS2) ? ~sign_a_q : sign_a_q) & (|sum_i);

  ////////////////////
  // control FSM
  ////////////////////

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state_q      <= ST_IDLE;
      sign_a_q     <= 1'b0;
      eff_sub_q    <= 1'b0;
      add_valid_o  <= 1'b0;
      add_cin_o    <= 1'b0;
      resp_valid_o <= 1'b0;
      resp_sign_o  <= 1'b0;
      resp_carry_o <= 1'b0;
    end else begin
      // single cycle pulses
      add_valid_o  <= 1'b0;
      resp_valid_o <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (pop_o) begin
            sign_a_q    <= head_a_sign_i;
            eff_sub_q   <= head_eff_sub;
            // carry in completes the two's complement of B
            add_cin_o   <= head_eff_sub;
            add_valid_o <= 1'b1;
            state_q     <= ST_PASS1;
          end
        end
        ST_PASS1: begin
          if (issue_p2) begin
            // swapped pass, B + ~A + 1
            add_cin_o   <= 1'b1;
            add_valid_o <= 1'b1;
            state_q     <= ST_PASS2;
          end else if (finish) begin
            state_q <= ST_DONE;
          end
        end
        ST_PASS2: begin
          if (finish) begin
            state_q <= ST_DONE;
          end
        end
        // result is on the outputs this cycle
        ST_DONE: begin
          state_q <= ST_IDLE;
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
      if (finish) begin
        resp_valid_o <= 1'b1;
        resp_sign_o  <= res_sign;
        // carry only means something for an effective add
        resp_carry_o <= ~eff_sub_q & cout_i;
      end
    end
  end

  ////////////////////
  // operand and result data
  ////////////////////

  always_ff @(posedge clk) begin
    if (pop_o) begin
      a_q     <= head_a_i;
      b_q     <= head_b_i;
      add_a_o <= head_a_i;
      // subtrahend inverted on the way in
      add_b_o <= head_eff_sub ? ~head_b_i : head_b_i;
    end else if (issue_p2) begin
      add_a_o <= b_q;
      add_b_o <= ~a_q;
    end
    // held until the next result
    if (finish) begin
      resp_mag_o <= sum_i;
    end
  end

endmodule

// File: hw/cmd_credit_buffer.sv
`timescale 1ns/100ps

module cmd_credit_buffer (
  input  logic                             clk,
  input  logic                             reset_n,
  // command side
  input  logic                             cmd_valid_i,
  input  ecc_arith_pkg::arith_op_e         cmd_op_i,
  input  logic [ecc_arith_pkg::WORD_W-1:0] cmd_a_i,
  input  logic [ecc_arith_pkg::WORD_W-1:0] cmd_b_i,
  input  logic                             cmd_a_sign_i,
  input  logic                             cmd_b_sign_i,
  // head entry
  input  logic                             pop_i,
  output logic                             head_valid_o,
  output ecc_arith_pkg::arith_op_e         head_op_o,
  output logic [ecc_arith_pkg::WORD_W-1:0] head_a_o,
  output logic [ecc_arith_pkg::WORD_W-1:0] head_b_o,
  output logic                             head_a_sign_o,
  output logic                             head_b_sign_o,
  // credit return
  output logic                             credit_o
);

  import ecc_arith_pkg::*;
  import ecc_flow_pkg::*;

  // entry storage
  arith_op_e         op_mem     [CMD_DEPTH];
  logic [WORD_W-1:0] a_mem      [CMD_DEPTH];
  logic [WORD_W-1:0] b_mem      [CMD_DEPTH];
  logic              a_sign_mem [CMD_DEPTH];
  logic              b_sign_mem [CMD_DEPTH];

  logic [CMD_PTR_W-1:0] wr_ptr_q;
  logic [CMD_PTR_W-1:0] rd_ptr_q;
  // one extra bit to tell full from empty
  logic [CMD_PTR_W:0]   count_q;

  logic do_pop;

  // sender never writes without a credit, so no full check here
  always_ff @(posedge clk) begin
    if (cmd_valid_i) begin
      op_mem[wr_ptr_q]     <= cmd_op_i;
      a_mem[wr_ptr_q]      <= cmd_a_i;
      b_mem[wr_ptr_q]      <= cmd_b_i;
      a_sign_mem[wr_ptr_q] <= cmd_a_sign_i;
      b_sign_mem[wr_ptr_q] <= cmd_b_sign_i;
    end
  end

  assign do_pop = pop_i & head_valid_o;

  // pointers wrap on their own, depth is 2**CMD_PTR_W
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (cmd_valid_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({cmd_valid_i, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // head is read straight from storage
  assign head_valid_o  = (count_q != '0);
  assign head_op_o     = op_mem[rd_ptr_q];
  assign head_a_o      = a_mem[rd_ptr_q];
  assign head_b_o      = b_mem[rd_ptr_q];
  assign head_a_sign_o = a_sign_mem[rd_ptr_q];
  assign head_b_sign_o = b_sign_mem[rd_ptr_q];

  // freed slot goes back to the sender right away
  assign credit_o = do_pop;

endmodule

// File: hw/ksa_adder.sv
`timescale 1ns/100ps

module ksa_adder (
  input  logic                             clk,
  input  logic                             reset_n,
  // operand side
  input  logic                             valid_i,
  input  logic [ecc_arith_pkg::WORD_W-1:0] a_i,
  input  logic [ecc_arith_pkg::WORD_W-1:0] b_i,
  input  logic                             cin_i,
  // result side
  output logic                             valid_o,
  output logic [ecc_arith_pkg::WORD_W-1:0] sum_o,
  output logic                             cout_o
);

  import ecc_arith_pkg::*;

  // group generate per stage, index 0 is the input stage
  logic [WORD_W-1:0] g_q [KSA_LEVELS+1];
  // group propagate, last level never needs one
  logic [WORD_W-1:0] p_q [KSA_LEVELS];
  // half-sum bits and carry in, delayed for the sum stage
  logic [WORD_W-1:0] hp_q [KSA_LEVELS+1];
  logic              cin_q [KSA_LEVELS+1];

  // valid travels beside the data
  logic [KSA_LATENCY-1:0] valid_sr;

  // bitwise generate / propagate ahead of the input register
  logic [WORD_W-1:0] g_in;
  logic [WORD_W-1:0] p_in;

  ////////////////////
  // input stage
  ////////////////////

  always_comb begin
    p_in = a_i ^ b_i;
    g_in = a_i & b_i;
    // carry in becomes part of the bit 0 generate
    g_in[0] = g_in[0] | (p_in[0] & cin_i);
  end

  always_ff @(posedge clk) begin
    g_q[0]   <= g_in;
    p_q[0]   <= p_in;
    hp_q[0]  <= p_in;
    cin_q[0] <= cin_i;
  end

  ////////////////////
  // prefix levels
  ////////////////////

  for (genvar lvl = 0; lvl < KSA_LEVELS; lvl++) begin : g_level
    // span doubles each level, 1 up to 128
    localparam int DIST = 1 << lvl;

    always_ff @(posedge clk) begin
      // zeros shift in below DIST, those bits already reach bit 0
      g_q[lvl+1]   <= g_q[lvl] | (p_q[lvl] & (g_q[lvl] << DIST));
      hp_q[lvl+1]  <= hp_q[lvl];
      cin_q[lvl+1] <= cin_q[lvl];
    end

    if (lvl < KSA_LEVELS - 1) begin : g_prop
      // low bits go to 0, they are never used as an upper group again
      always_ff @(posedge clk) begin
        p_q[lvl+1] <= p_q[lvl] & (p_q[lvl] << DIST);
      end
    end
  end

  ////////////////////
  // sum stage
  ////////////////////

  // carry into bit i is the group generate of bits i-1..0
  always_ff @(posedge clk) begin
    sum_o  <= hp_q[KSA_LEVELS] ^ {g_q[KSA_LEVELS][WORD_W-2:0], cin_q[KSA_LEVELS]};
    cout_o <= g_q[KSA_LEVELS][WORD_W-1];
  end

  // one flop per data stage
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      valid_sr <= '0;
    end else begin
      valid_sr <= {valid_sr[KSA_LATENCY-2:0], valid_i};
    end
  end

  assign valid_o = valid_sr[KSA_LATENCY-1];

endmodule

// File: hw/ecc_flow_pkg.sv
package ecc_flow_pkg;

  ////////////////////
  // command buffer
  ////////////////////

  // buffer entries, sender starts with this many credits
  localparam int CMD_DEPTH = 4;

  // pointer width, depth is a power of two so pointers wrap by themselves
  localparam int CMD_PTR_W = 2;

  ////////////////////
  // wrapper control
  ////////////////////

  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0,
    ST_PASS1 = 2'd1,
    ST_PASS2 = 2'd2,
    ST_DONE  = 2'd3
  } unit_state_e;

endpackage

// File: hw/ecc_arith_pkg.sv
package ecc_arith_pkg;

  ////////////////////
  // operand geometry
  ////////////////////

  // magnitude width of every operand and result
  localparam int WORD_W = 256;

  // kogge-stone prefix depth, log2 of WORD_W
  localparam int KSA_LEVELS = 8;

  // input stage + one register per prefix level + sum stage
  localparam int KSA_LATENCY = KSA_LEVELS + 2;

  ////////////////////
  // command opcodes
  ////////////////////

  // requested operation, before the signs are taken into account
  typedef enum logic {
    OP_ADD = 1'b0,
    OP_SUB = 1'b1
  } arith_op_e;

endpackage
